// File: hw/dbg_params.svh
// Debug network parameters.
// Flit and id widths, the identity words of the UART emulation module
// and the reset value of its event destination.

`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

// Width of one flit word on every debug channel.
`define DBG_FLIT_W 16

// Width of a module id on the debug network.
`define DBG_ID_W 16

// Vendor code returned by the MOD_VENDOR register.
`define DBG_MOD_VENDOR 16'h0001

// Module type code for the UART device emulation.
`define DBG_MOD_TYPE_UART 16'h0002

// Version code returned by the MOD_VERSION register.
`define DBG_MOD_VERSION 16'h0000

// Event destination after reset, which is the host.
`define DBG_EVENT_DEST_DEFAULT 16'h0000

`endif

// File: hw/dii_pkg.sv
// Debug interconnect package.
// Packet types and subtypes and the layout of the flags header word.

`include "dbg_params.svh"

package dii_pkg;

  localparam int TYPE_POS    = 14; // Type field sits in the top two bits.
  localparam int TYPE_W      = 2;
  localparam int SUBTYPE_POS = 10; // Subtype sits just below the type.
  localparam int SUBTYPE_W   = 4;

  typedef enum logic [TYPE_W-1:0] {
    REG   = 2'b00, // Register access request or response.
    EVENT = 2'b10  // Module event, here a UART character.
  } dii_type_e;

  typedef enum logic [SUBTYPE_W-1:0] {
    REQ_READ_16     = 4'b0000,
    REQ_WRITE_16    = 4'b0100,
    RESP_READ_OK_16 = 4'b1000,
    RESP_READ_ERR   = 4'b1100,
    RESP_WRITE_OK   = 4'b1110,
    RESP_WRITE_ERR  = 4'b1111
  } dii_subtype_e;

  // Event subtype; it shares its code with REQ_READ_16.
  localparam logic [SUBTYPE_W-1:0] EVENT_LAST = 4'b0000;

  // Builds a flags word, the bits below the subtype stay zero.
  function automatic logic [`DBG_FLIT_W-1:0] make_flags(dii_type_e t,
                                                        logic [SUBTYPE_W-1:0] st);
    logic [`DBG_FLIT_W-1:0] f;
    f = '0;
    f[TYPE_POS +: TYPE_W] = t;
    f[SUBTYPE_POS +: SUBTYPE_W] = st;
    return f;
  endfunction

endpackage

// File: hw/dem_pkg.sv
// UART device emulation package.
// Register map and the state encodings of the module's FSMs.

`include "dbg_params.svh"

package dem_pkg;

  typedef enum logic [`DBG_FLIT_W-1:0] {
    MOD_VENDOR     = 16'h0000,
    MOD_TYPE       = 16'h0001,
    MOD_VERSION    = 16'h0002,
    MOD_CS         = 16'h0003, // Control/status word.
    MOD_EVENT_DEST = 16'h0004  // Where character events are sent.
  } dem_reg_e;

  localparam int CS_ACTIVE = 0; // Active bit in MOD_CS, set clears the stall.

  // Transmit side, one state per packet word plus idle.
  typedef enum logic [2:0] {
    TX_IDLE, TX_HDR_DEST, TX_HDR_SRC, TX_HDR_FLAGS, TX_XFER
  } tx_state_e;

  // Receive side; idle swallows the destination word.
  typedef enum logic [1:0] {
    RX_IDLE, RX_HDR_SRC, RX_HDR_FLAGS, RX_XFER
  } rx_state_e;

  // Register access input parser.
  typedef enum logic [2:0] {
    RA_HDR_DEST, RA_HDR_SRC, RA_HDR_FLAGS, RA_PAYLOAD, RA_FWD, RA_DISCARD, RA_RESP
  } ra_state_e;

endpackage

// File: hw/dii_if.sv
// Debug flit channel.
// One word per transfer, moved when valid and ready are both high.

`timescale 1ns/10ps
`include "dbg_params.svh"

interface dii_if;

  logic [`DBG_FLIT_W-1:0] data;  // Flit word.
  logic                   last;  // Marks the final word of a packet.
  logic                   valid; // Sender offers a word.
  logic                   ready; // Receiver takes the word.

  modport sender (
    output data,
    output last,
    output valid,
    input  ready
  );

  modport receiver (
    input  data,
    input  last,
    input  valid,
    output ready
  );

endinterface

// File: hw/osd_regaccess.sv
// Register access layer of a debug module.
// Parses packets from the host, answers register requests, forwards events
// to the module and merges module packets with responses on the way out.

`timescale 1ns/10ps
`include "dbg_params.svh"

module osd_regaccess #(
  parameter logic [`DBG_FLIT_W-1:0] MOD_TYPE = `DBG_MOD_TYPE_UART
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`DBG_ID_W-1:0] id,
  dii_if.receiver              debug_in,
  dii_if.sender                debug_out,
  dii_if.receiver              module_in,
  dii_if.sender                module_out,
  output logic                 stall,
  output logic [`DBG_ID_W-1:0] event_dest
);

  dem_pkg::ra_state_e        ra_state;
  logic [`DBG_FLIT_W-1:0]    hdr_dest;
  logic [`DBG_FLIT_W-1:0]    hdr_src;
  logic [`DBG_FLIT_W-1:0]    hdr_flags;
  logic [`DBG_FLIT_W-1:0]    hdr_word;
  logic [1:0]                fwd_cnt;
  logic                      fwd_hdr;
  logic                      pl_idx;
  logic                      req_write;
  logic                      req_done;
  logic [`DBG_FLIT_W-1:0]    req_addr;
  dem_pkg::dem_reg_e         eff_addr;
  dii_pkg::dii_type_e        in_type;
  logic [dii_pkg::SUBTYPE_W-1:0] in_sub;
  logic                      to_me;
  logic                      rd_ok;
  logic                      wr_ok;
  logic [`DBG_FLIT_W-1:0]    rd_data;
  logic [1:0]                resp_idx;
  logic [`DBG_FLIT_W-1:0]    resp_dest;
  logic [`DBG_FLIT_W-1:0]    resp_flags;
  logic [`DBG_FLIT_W-1:0]    resp_data;
  logic                      resp_four;
  logic [`DBG_FLIT_W-1:0]    resp_word;
  logic                      resp_last;
  logic                      resp_pend;
  logic                      out_active;
  logic                      sel_mod;
  logic                      grant_mod;

  assign in_type = dii_pkg::dii_type_e'(debug_in.data[dii_pkg::TYPE_POS +: dii_pkg::TYPE_W]);
  assign in_sub  = debug_in.data[dii_pkg::SUBTYPE_POS +: dii_pkg::SUBTYPE_W];
  assign to_me   = (hdr_dest == id); // Destination word is already captured.

  // A read has its address on the last word, a write on the word before.
  assign eff_addr = dem_pkg::dem_reg_e'(pl_idx ? req_addr : debug_in.data);
  assign req_done = (ra_state == dem_pkg::RA_PAYLOAD) && debug_in.valid && debug_in.last;
  assign wr_ok    = pl_idx && (eff_addr == dem_pkg::MOD_CS ||
                               eff_addr == dem_pkg::MOD_EVENT_DEST);

  always_comb begin
    rd_ok   = 1'b1;
    rd_data = '0;
    case (eff_addr)
      dem_pkg::MOD_VENDOR:     rd_data = `DBG_MOD_VENDOR;
      dem_pkg::MOD_TYPE:       rd_data = MOD_TYPE;
      dem_pkg::MOD_VERSION:    rd_data = `DBG_MOD_VERSION;
      dem_pkg::MOD_CS:         rd_data[dem_pkg::CS_ACTIVE] = ~stall;
      dem_pkg::MOD_EVENT_DEST: rd_data = event_dest;
      default:                 rd_ok = 1'b0; // Unknown address reads as an error.
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ra_state   <= dem_pkg::RA_HDR_DEST;
      fwd_cnt    <= '0;
      pl_idx     <= 1'b0;
      resp_idx   <= '0;
      stall      <= 1'b1; // Module starts stalled until the host activates it.
      event_dest <= `DBG_EVENT_DEST_DEFAULT;
    end else begin
      case (ra_state)
        dem_pkg::RA_HDR_DEST: begin
          if (debug_in.valid && !debug_in.last) ra_state <= dem_pkg::RA_HDR_SRC;
        end
        dem_pkg::RA_HDR_SRC: begin
          if (debug_in.valid) begin
            ra_state <= debug_in.last ? dem_pkg::RA_HDR_DEST : dem_pkg::RA_HDR_FLAGS;
          end
        end
        dem_pkg::RA_HDR_FLAGS: begin
          pl_idx  <= 1'b0;
          fwd_cnt <= '0;
          if (debug_in.valid) begin
            if (debug_in.last) begin
              ra_state <= dem_pkg::RA_HDR_DEST; // Header only packet carries nothing.
            end else if (to_me && in_type == dii_pkg::REG &&
                         (in_sub == dii_pkg::REQ_READ_16 || in_sub == dii_pkg::REQ_WRITE_16)) begin
              ra_state <= dem_pkg::RA_PAYLOAD;
            end else if (to_me && in_type == dii_pkg::EVENT) begin
              ra_state <= dem_pkg::RA_FWD;
            end else begin
              ra_state <= dem_pkg::RA_DISCARD;
            end
          end
        end
        dem_pkg::RA_PAYLOAD: begin
          if (debug_in.valid) pl_idx <= 1'b1;
          if (req_done) begin
            ra_state <= dem_pkg::RA_RESP;
            resp_idx <= '0;
            if (req_write && wr_ok && eff_addr == dem_pkg::MOD_CS) begin
              stall <= ~debug_in.data[dem_pkg::CS_ACTIVE];
            end
            if (req_write && wr_ok && eff_addr == dem_pkg::MOD_EVENT_DEST) begin
              event_dest <= debug_in.data;
            end
          end
        end
        dem_pkg::RA_FWD: begin
          if (fwd_hdr && module_out.ready) begin
            fwd_cnt <= fwd_cnt + 2'd1; // Replay the buffered headers first.
          end else if (!fwd_hdr && debug_in.valid && module_out.ready && debug_in.last) begin
            ra_state <= dem_pkg::RA_HDR_DEST;
          end
        end
        dem_pkg::RA_DISCARD: begin
          if (debug_in.valid && debug_in.last) ra_state <= dem_pkg::RA_HDR_DEST;
        end
        dem_pkg::RA_RESP: begin
          if (debug_out.valid && debug_out.ready && !grant_mod) begin
            if (resp_last) ra_state <= dem_pkg::RA_HDR_DEST;
            else resp_idx <= resp_idx + 2'd1;
          end
        end
        default: ra_state <= dem_pkg::RA_HDR_DEST;
      endcase
    end
  end

  // Header words and the response buffer.
  always_ff @(posedge clk) begin
    if (debug_in.valid && debug_in.ready) begin
      case (ra_state)
        dem_pkg::RA_HDR_DEST: hdr_dest <= debug_in.data;
        dem_pkg::RA_HDR_SRC:  hdr_src  <= debug_in.data;
        dem_pkg::RA_HDR_FLAGS: begin
          hdr_flags <= debug_in.data;
          req_write <= (in_sub == dii_pkg::REQ_WRITE_16);
        end
        dem_pkg::RA_PAYLOAD: begin
          if (!pl_idx) req_addr <= debug_in.data;
          if (debug_in.last) begin
            resp_dest <= hdr_src; // Answer goes back to the requester.
            resp_data <= rd_data;
            resp_four <= !req_write && rd_ok;
            if (req_write) begin
              resp_flags <= dii_pkg::make_flags(dii_pkg::REG, wr_ok ? dii_pkg::RESP_WRITE_OK
                                                                   : dii_pkg::RESP_WRITE_ERR);
            end else begin
              resp_flags <= dii_pkg::make_flags(dii_pkg::REG, rd_ok ? dii_pkg::RESP_READ_OK_16
                                                                   : dii_pkg::RESP_READ_ERR);
            end
          end
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    case (resp_idx)
      2'd0:    resp_word = resp_dest;
      2'd1:    resp_word = id;
      2'd2:    resp_word = resp_flags;
      default: resp_word = resp_data;
    endcase
    case (fwd_cnt)
      2'd0:    hdr_word = hdr_dest;
      2'd1:    hdr_word = hdr_src;
      default: hdr_word = hdr_flags;
    endcase
  end

  assign resp_last = (resp_idx == 2'd3) || (resp_idx == 2'd2 && !resp_four);

  // Event forwarding, headers are replayed then payload passes through.
  assign fwd_hdr          = (fwd_cnt != 2'd3);
  assign module_out.valid = (ra_state == dem_pkg::RA_FWD) && (fwd_hdr || debug_in.valid);
  assign module_out.data  = fwd_hdr ? hdr_word : debug_in.data;
  assign module_out.last  = !fwd_hdr && debug_in.last;

  always_comb begin
    case (ra_state)
      dem_pkg::RA_RESP: debug_in.ready = 1'b0; // Input is closed while a response waits.
      dem_pkg::RA_FWD:  debug_in.ready = !fwd_hdr && module_out.ready;
      default:          debug_in.ready = 1'b1;
    endcase
  end

  // Output arbiter, locked to one source from first offer to last word.
  assign resp_pend        = (ra_state == dem_pkg::RA_RESP);
  assign grant_mod        = out_active ? sel_mod : !resp_pend;
  assign debug_out.valid  = grant_mod ? module_in.valid : resp_pend;
  assign debug_out.data   = grant_mod ? module_in.data : resp_word;
  assign debug_out.last   = grant_mod ? module_in.last : resp_last;
  assign module_in.ready  = grant_mod && debug_out.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_active <= 1'b0;
      sel_mod    <= 1'b1;
    end else if (debug_out.valid) begin
      out_active <= !(debug_out.ready && debug_out.last);
      sel_mod    <= grant_mod;
    end
  end

  // A word waiting on debug_out keeps its value whichever source owns it.
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    debug_out.valid && !debug_out.ready |=>
      debug_out.valid && $stable(debug_out.data) && $stable(debug_out.last));

  // The input reopens only after the last response word has left debug_out.
  a_in_closed: assert property (@(posedge clk) disable iff (rst)
    $past(resp_pend) && debug_in.ready |->
      $past(debug_out.valid && debug_out.ready && debug_out.last));

endmodule

// File: hw/dem_uart.sv
// UART device emulation.
// Wraps each transmitted character into an event packet and turns the
// payload of incoming event packets into received characters.

`timescale 1ns/10ps
`include "dbg_params.svh"

module dem_uart (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`DBG_ID_W-1:0] id,
  input  logic                 stall,
  input  logic [`DBG_ID_W-1:0] event_dest,
  dii_if.sender                ev_out,
  dii_if.receiver              ev_in,
  input  logic [7:0]           out_char,
  input  logic                 out_valid,
  output logic                 out_ready,
  output logic [7:0]           in_char,
  output logic                 in_valid,
  input  logic                 in_ready
);

  dem_pkg::tx_state_e   tx_state;
  dem_pkg::rx_state_e   rx_state;
  logic [7:0]           char_buf; // Character being sent.
  logic [`DBG_ID_W-1:0] dest_buf; // Destination frozen for the whole packet.

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_state <= dem_pkg::TX_IDLE;
      rx_state <= dem_pkg::RX_IDLE;
    end else begin
      case (tx_state)
        dem_pkg::TX_IDLE:      if (out_valid && out_ready) tx_state <= dem_pkg::TX_HDR_DEST;
        dem_pkg::TX_HDR_DEST:  if (ev_out.ready) tx_state <= dem_pkg::TX_HDR_SRC;
        dem_pkg::TX_HDR_SRC:   if (ev_out.ready) tx_state <= dem_pkg::TX_HDR_FLAGS;
        dem_pkg::TX_HDR_FLAGS: if (ev_out.ready) tx_state <= dem_pkg::TX_XFER;
        dem_pkg::TX_XFER:      if (ev_out.ready) tx_state <= dem_pkg::TX_IDLE;
        default:               tx_state <= dem_pkg::TX_IDLE;
      endcase

      // Header words are skipped one per valid cycle.
      case (rx_state)
        dem_pkg::RX_IDLE:      if (ev_in.valid) rx_state <= dem_pkg::RX_HDR_SRC;
        dem_pkg::RX_HDR_SRC:   if (ev_in.valid) rx_state <= dem_pkg::RX_HDR_FLAGS;
        dem_pkg::RX_HDR_FLAGS: if (ev_in.valid) rx_state <= dem_pkg::RX_XFER;
        dem_pkg::RX_XFER: begin
          if (ev_in.valid && in_ready && ev_in.last) rx_state <= dem_pkg::RX_IDLE;
        end
        default:               rx_state <= dem_pkg::RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (out_valid && out_ready) begin
      char_buf <= out_char;
      dest_buf <= event_dest;
    end
  end

  assign out_ready = (tx_state == dem_pkg::TX_IDLE) && !stall; // Stalled module takes nothing.

  always_comb begin
    ev_out.valid = (tx_state != dem_pkg::TX_IDLE);
    ev_out.last  = (tx_state == dem_pkg::TX_XFER);
    case (tx_state)
      dem_pkg::TX_HDR_DEST:  ev_out.data = dest_buf;
      dem_pkg::TX_HDR_SRC:   ev_out.data = id;
      dem_pkg::TX_HDR_FLAGS: ev_out.data = dii_pkg::make_flags(dii_pkg::EVENT,
                                                               dii_pkg::EVENT_LAST);
      default:               ev_out.data = {{(`DBG_FLIT_W-8){1'b0}}, char_buf};
    endcase
  end

  // The payload word waits on in_ready, headers never wait.
  assign ev_in.ready = (rx_state == dem_pkg::RX_XFER) ? in_ready : 1'b1;
  assign in_valid    = (rx_state == dem_pkg::RX_XFER) && ev_in.valid;
  assign in_char     = ev_in.data[7:0];

  // An accepted character keeps the transmitter busy for all four words.
  a_tx_busy: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready |=> !out_ready [*4]);

endmodule

// File: hw/dem_uart_top.sv
// UART device emulation top level.
// Maps the plain debug and character ports onto flit channels and joins
// the register access layer with the UART block.

`timescale 1ns/10ps
`include "dbg_params.svh"

module dem_uart_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`DBG_ID_W-1:0]   id,
  input  logic [`DBG_FLIT_W-1:0] debug_in_data,
  input  logic                   debug_in_last,
  input  logic                   debug_in_valid,
  output logic                   debug_in_ready,
  output logic [`DBG_FLIT_W-1:0] debug_out_data,
  output logic                   debug_out_last,
  output logic                   debug_out_valid,
  input  logic                   debug_out_ready,
  output logic                   drop,
  input  logic [7:0]             out_char,
  input  logic                   out_valid,
  output logic                   out_ready,
  output logic [7:0]             in_char,
  output logic                   in_valid,
  input  logic                   in_ready
);

  logic                 stall;
  logic [`DBG_ID_W-1:0] event_dest;

  dii_if dbg_in ();     // Host to register access.
  dii_if dbg_out ();    // Register access to host.
  dii_if uart_to_ra (); // Character events leaving the UART.
  dii_if ra_to_uart (); // Events for the UART receiver.

  assign dbg_in.data     = debug_in_data;
  assign dbg_in.last     = debug_in_last;
  assign dbg_in.valid    = debug_in_valid;
  assign debug_in_ready  = dbg_in.ready;
  assign debug_out_data  = dbg_out.data;
  assign debug_out_last  = dbg_out.last;
  assign debug_out_valid = dbg_out.valid;
  assign dbg_out.ready   = debug_out_ready;
  assign drop            = stall; // Characters are dropped while stalled.

  osd_regaccess #(.MOD_TYPE(`DBG_MOD_TYPE_UART)) u_regaccess (
    .clk        (clk),
    .rst        (rst),
    .id         (id),
    .debug_in   (dbg_in.receiver),
    .debug_out  (dbg_out.sender),
    .module_in  (uart_to_ra.receiver),
    .module_out (ra_to_uart.sender),
    .stall      (stall),
    .event_dest (event_dest)
  );

  dem_uart u_uart (
    .clk        (clk),
    .rst        (rst),
    .id         (id),
    .stall      (stall),
    .event_dest (event_dest),
    .ev_out     (uart_to_ra.sender),
    .ev_in      (ra_to_uart.receiver),
    .out_char   (out_char),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .in_char    (in_char),
    .in_valid   (in_valid),
    .in_ready   (in_ready)
  );

endmodule

// File: test/tb_dem_uart.sv
// Testbench for the UART device emulation top level.
// A host model sends register and event packets and offers characters.
// Every debug_out word and every received character is checked against a model.

`timescale 1ns/10ps
`include "dbg_params.svh"

module tb_dem_uart;

  localparam logic [`DBG_ID_W-1:0] DUT_ID     = 16'h0005;
  localparam logic [`DBG_ID_W-1:0] HOST_ID    = 16'h0001;
  localparam logic [`DBG_ID_W-1:0] FOREIGN_ID = 16'h0007; // Nobody on this id answers.
  localparam int                   TIMEOUT    = 2000;     // Cycles allowed for one wait.
  localparam int                   NUM_CHARS  = 20;
  localparam logic [1:0]           T_REG      = 2'b00;
  localparam logic [1:0]           T_EVENT    = 2'b10;
  localparam logic [3:0]           ST_RD_REQ  = 4'b0000;
  localparam logic [3:0]           ST_WR_REQ  = 4'b0100;
  localparam logic [3:0]           ST_RD_OK   = 4'b1000;
  localparam logic [3:0]           ST_RD_ERR  = 4'b1100;
  localparam logic [3:0]           ST_WR_OK   = 4'b1110;
  localparam logic [3:0]           ST_WR_ERR  = 4'b1111;
  localparam logic [3:0]           ST_EV_LAST = 4'b0000;

  logic                   clk             = 1'b0;
  logic                   rst             = 1'b1;
  logic [`DBG_FLIT_W-1:0] debug_in_data   = '0;
  logic                   debug_in_last   = 1'b0;
  logic                   debug_in_valid  = 1'b0;
  logic                   debug_out_ready = 1'b1;
  logic [7:0]             out_char        = '0;
  logic                   out_valid       = 1'b0;
  logic                   in_ready        = 1'b1;
  logic                   rand_out_rdy    = 1'b0; // Toggle debug_out_ready at random.
  logic                   rand_in_rdy     = 1'b0; // Toggle in_ready at random.
  logic                   debug_in_ready;
  logic [`DBG_FLIT_W-1:0] debug_out_data;
  logic                   debug_out_last;
  logic                   debug_out_valid;
  logic                   drop;
  logic                   out_ready;
  logic [7:0]             in_char;
  logic                   in_valid;
  logic [16:0]            out_q[$];     // Words seen on debug_out, last flag on top.
  logic [16:0]            exp_q[$];     // Words the model expects on debug_out.
  logic [7:0]             rx_q[$];      // Characters taken from in_char.
  logic [7:0]             exp_chars[$];
  logic                   m_active     = 1'b0;
  logic [`DBG_ID_W-1:0]   m_event_dest = `DBG_EVENT_DEST_DEFAULT;
  int                     errors       = 0;
  int                     err_mark     = 0;
  int                     tests_run    = 0;
  int                     tests_ok     = 0;

  dem_uart_top dut (
    .clk             (clk),
    .rst             (rst),
    .id              (DUT_ID),
    .debug_in_data   (debug_in_data),
    .debug_in_last   (debug_in_last),
    .debug_in_valid  (debug_in_valid),
    .debug_in_ready  (debug_in_ready),
    .debug_out_data  (debug_out_data),
    .debug_out_last  (debug_out_last),
    .debug_out_valid (debug_out_valid),
    .debug_out_ready (debug_out_ready),
    .drop            (drop),
    .out_char        (out_char),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .in_char         (in_char),
    .in_valid        (in_valid),
    .in_ready        (in_ready)
  );

  always #20 clk = ~clk; // 40 ns period.

  // Both ready inputs follow the clock, random only while a test asks for it.
  always @(posedge clk) begin
    logic [31:0] bits;
    #2;
    bits = $urandom;
    debug_out_ready = rand_out_rdy ? bits[0] : 1'b1;
    in_ready        = rand_in_rdy ? bits[1] : 1'b1;
  end

  // Transfers are sampled mid cycle, where every signal has settled.
  always @(negedge clk) begin
    if (!rst && debug_out_valid && debug_out_ready) begin
      out_q.push_back({debug_out_last, debug_out_data});
    end
    if (!rst && in_valid && in_ready) rx_q.push_back(in_char);
  end

  function automatic logic [15:0] flag_word(input logic [1:0] ptype, input logic [3:0] sub);
    return {ptype, sub, 10'h000}; // Type in bits 15 to 14, subtype in bits 13 to 10.
  endfunction

  task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (exp !== act) begin
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timeout at %0t: %s.", $time, what);
    $display("tests failed");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      tests_ok++;
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: FAIL with %0d mismatches", tests_run, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // Caller stands 2 ns after a rising edge; so does the task when it returns.
  task automatic send_word(input logic [15:0] data, input logic last);
    int n;
    debug_in_data  = data;
    debug_in_last  = last;
    debug_in_valid = 1'b1;
    n = 0;
    @(negedge clk);
    while (!debug_in_ready) begin
      n++;
      if (n > TIMEOUT) fail_timeout("debug_in_ready stayed low");
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    debug_in_valid = 1'b0;
  endtask

  task automatic send_read(input logic [15:0] dest, input logic [15:0] addr);
    send_word(dest, 1'b0);
    send_word(HOST_ID, 1'b0);
    send_word(flag_word(T_REG, ST_RD_REQ), 1'b0);
    send_word(addr, 1'b1);
  endtask

  task automatic send_write(input logic [15:0] dest, input logic [15:0] addr,
                            input logic [15:0] data);
    send_word(dest, 1'b0);
    send_word(HOST_ID, 1'b0);
    send_word(flag_word(T_REG, ST_WR_REQ), 1'b0);
    send_word(addr, 1'b0);
    send_word(data, 1'b1);
  endtask

  task automatic send_event(input logic [15:0] dest, input logic [7:0] ch);
    send_word(dest, 1'b0);
    send_word(HOST_ID, 1'b0);
    send_word(flag_word(T_EVENT, ST_EV_LAST), 1'b0);
    send_word({8'h00, ch}, 1'b1);
  endtask

  task automatic offer_char(input logic [7:0] ch);
    int n;
    out_char  = ch;
    out_valid = 1'b1;
    n = 0;
    @(negedge clk);
    while (!out_ready) begin
      n++;
      if (n > TIMEOUT) fail_timeout("out_ready never rose for a character");
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    out_valid = 1'b0;
  endtask

  // Register file model, read side.
  task automatic expect_read(input logic [15:0] addr);
    logic        ok;
    logic [15:0] data;
    ok   = 1'b1;
    data = '0;
    case (addr)
      16'h0000: data = 16'h0001; // Vendor code.
      16'h0001: data = 16'h0002; // UART module type.
      16'h0002: data = 16'h0000; // Version.
      16'h0003: data = {15'h0000, m_active};
      16'h0004: data = m_event_dest;
      default:  ok = 1'b0;
    endcase
    exp_q.push_back({1'b0, HOST_ID});
    exp_q.push_back({1'b0, DUT_ID});
    if (ok) begin
      exp_q.push_back({1'b0, flag_word(T_REG, ST_RD_OK)});
      exp_q.push_back({1'b1, data});
    end else begin
      exp_q.push_back({1'b1, flag_word(T_REG, ST_RD_ERR)});
    end
  endtask

  // Register file model, write side; only control/status and event destination take writes.
  task automatic expect_write(input logic [15:0] addr, input logic [15:0] data);
    logic ok;
    ok = (addr == 16'h0003) || (addr == 16'h0004);
    if (addr == 16'h0003) m_active = data[0];
    if (addr == 16'h0004) m_event_dest = data;
    exp_q.push_back({1'b0, HOST_ID});
    exp_q.push_back({1'b0, DUT_ID});
    exp_q.push_back({1'b1, flag_word(T_REG, ok ? ST_WR_OK : ST_WR_ERR)});
  endtask

  task automatic expect_event(input logic [7:0] ch);
    exp_q.push_back({1'b0, m_event_dest});
    exp_q.push_back({1'b0, DUT_ID});
    exp_q.push_back({1'b0, flag_word(T_EVENT, ST_EV_LAST)});
    exp_q.push_back({1'b1, 8'h00, ch});
  endtask

  task automatic check_packets();
    int          n;
    logic [16:0] e;
    logic [16:0] a;
    n = 0;
    while (out_q.size() < exp_q.size()) begin
      n++;
      if (n > TIMEOUT) fail_timeout("debug_out packets did not arrive");
      @(posedge clk);
      #2;
    end
    while (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      a = out_q.pop_front();
      compare("debug_out_data", e[15:0], a[15:0]);
      compare("debug_out_last", 16'(e[16]), 16'(a[16]));
    end
  endtask

  task automatic check_chars();
    int n;
    n = 0;
    while (rx_q.size() < exp_chars.size()) begin
      n++;
      if (n > TIMEOUT) fail_timeout("received characters did not arrive");
      @(posedge clk);
      #2;
    end
    while (exp_chars.size() > 0) begin
      compare("in_char", 16'(exp_chars.pop_front()), 16'(rx_q.pop_front()));
    end
  endtask

  initial begin
    logic [31:0] rnd;
    rnd = $urandom(8);
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    compare("drop", 16'(1'b1), 16'(drop)); // Module comes out of reset stalled.
    compare("out_ready", 16'(1'b0), 16'(out_ready));
    compare("in_valid", 16'(1'b0), 16'(in_valid));
    compare("debug_out_valid", 16'(1'b0), 16'(debug_out_valid));
    compare("debug_in_ready", 16'(1'b1), 16'(debug_in_ready));
    end_test("reset values");

    for (int a = 0; a < 3; a++) begin
      send_read(DUT_ID, 16'(a));
      expect_read(16'(a));
      check_packets();
    end
    send_read(DUT_ID, 16'h0009);
    expect_read(16'h0009);
    check_packets();
    end_test("identity reads");

    rnd = $urandom;
    send_write(DUT_ID, 16'h0004, rnd[15:0]);
    expect_write(16'h0004, rnd[15:0]);
    send_write(DUT_ID, 16'h0003, 16'h0001); // Sets the active bit.
    expect_write(16'h0003, 16'h0001);
    send_read(DUT_ID, 16'h0004);
    expect_read(16'h0004);
    send_read(DUT_ID, 16'h0003);
    expect_read(16'h0003);
    check_packets();
    compare("drop", 16'(!m_active), 16'(drop));
    send_write(DUT_ID, 16'h0000, 16'h00ff); // Vendor is read only.
    expect_write(16'h0000, 16'h00ff);
    send_read(DUT_ID, 16'h0000);
    expect_read(16'h0000);
    check_packets();
    end_test("register writes");

    rand_out_rdy = 1'b1;
    for (int i = 0; i < NUM_CHARS; i++) begin
      rnd = $urandom;
      expect_event(rnd[7:0]);
      offer_char(rnd[7:0]);
    end
    check_packets();
    rand_out_rdy = 1'b0;
    end_test("transmitted characters");

    rand_in_rdy = 1'b1;
    for (int i = 0; i < NUM_CHARS; i++) begin
      rnd = $urandom;
      exp_chars.push_back(rnd[7:0]);
      send_event(DUT_ID, rnd[7:0]);
    end
    check_chars();
    rand_in_rdy = 1'b0;
    end_test("received characters");

    send_read(FOREIGN_ID, 16'h0000);
    send_write(FOREIGN_ID, 16'h0003, 16'h0000); // Would stall the module if taken.
    send_event(FOREIGN_ID, 8'h5a);
    send_read(DUT_ID, 16'h0001);
    expect_read(16'h0001);
    check_packets();
    compare("debug_out extra words", 16'h0000, 16'(out_q.size()));
    compare("in_valid characters", 16'h0000, 16'(rx_q.size()));
    compare("drop", 16'(!m_active), 16'(drop));
    end_test("foreign packets");

    $display("tests run %0d, ok %0d, mismatches %0d", tests_run, tests_ok, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+hw
hw/dii_pkg.sv
hw/dem_pkg.sv
hw/dii_if.sv
hw/osd_regaccess.sv
hw/dem_uart.sv
hw/dem_uart_top.sv
test/tb_dem_uart.sv

// File: run_sim.sh
#!/bin/sh
# Compiles the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_dem_uart -o sim_dem_uart
./obj_dir/sim_dem_uart > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
  echo "Simulation reported a failure."
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  echo "Simulation ended without a result."
  exit 1
fi
echo "Simulation finished cleanly."
